// File: design/posit_accum_pkg.sv
////////////////////////////////////////////////////////////
// Widths, loop depth and stage structs shared by the
// posit accumulator pipeline
////////////////////////////////////////////////////////////
`default_nettype none

package posit_accum_pkg;

    localparam int SCALE_W    = 9;
    localparam int FRAC_W     = 26;
    localparam int ACC_FRAC_W = 40;
    localparam int LOOP_DEPTH = 5;
    localparam int LOD_W      = 6;

    // Accumulator magnitude with its hidden bit
    localparam int MAG_W      = ACC_FRAC_W + 1;
    localparam int CLR_CNT_W  = $clog2(LOOP_DEPTH);

    // Unpacked posit input, 38 bits
    typedef struct packed {
        logic                      sgn;
        logic signed [SCALE_W-1:0] scale;
        logic [FRAC_W-1:0]         fraction;
        logic                      inf;
        logic                      zero;
    } posit_value_t;

    // Accumulator value, 52 bits
    typedef struct packed {
        logic                      sgn;
        logic signed [SCALE_W-1:0] scale;
        logic [ACC_FRAC_W-1:0]     fraction;
        logic                      inf;
        logic                      zero;
    } accum_value_t;

    localparam accum_value_t ACC_ZERO = '{
        sgn: 1'b0, scale: '0, fraction: '0, inf: 1'b0, zero: 1'b1
    };

    typedef struct packed {
        accum_value_t       hi;
        accum_value_t       lo;
        logic               subtract;
        logic [SCALE_W-1:0] scale_diff;
    } order_stage_t;

    typedef struct packed {
        accum_value_t     hi;
        logic [MAG_W-1:0] lo_mag;
        logic             lo_inf;
        logic             lo_zero;
        logic             subtract;
        logic             truncated;
    } align_stage_t;

    typedef struct packed {
        logic                      sgn;
        logic signed [SCALE_W-1:0] scale;
        logic                      inf;
        logic                      zero;
        logic [MAG_W:0]            raw;
        logic                      truncated;
    } sum_stage_t;

    typedef struct packed {
        sum_stage_t                sum;
        logic [LOD_W-1:0]          lod_pos;
        logic signed [SCALE_W-1:0] scale_adj;
    } norm_stage_t;

endpackage

`default_nettype wire

// File: design/accum_ctrl.sv
////////////////////////////////////////////////////////////
// Accumulator control: start-to-done delay chain and the
// lane clear counter
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module accum_ctrl
    import posit_accum_pkg::*;
(
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic start,
    input  wire logic clear,
    output logic      acc_clear,
    output logic      done
);

    logic [LOOP_DEPTH-1:0] start_sr;
    logic [CLR_CNT_W-1:0]  clr_cnt;

    // Start travels alongside the datapath, one bit per stage
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            start_sr <= '0;
        end
        else
        begin
            start_sr <= {start_sr[LOOP_DEPTH-2:0], start};
        end
    end

    assign done = start_sr[LOOP_DEPTH-1];

    // Counts the remaining lanes still to be wiped after a clear
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            clr_cnt <= '0;
        end
        else if (clear)
        begin
            clr_cnt <= CLR_CNT_W'(LOOP_DEPTH - 1);
        end
        else if (clr_cnt != '0)
        begin
            clr_cnt <= clr_cnt - 1'b1;
        end
    end

    // The edge that samples clear already wipes its own lane,
    // the counter covers the other lanes
    assign acc_clear = clear | (clr_cnt != '0);

endmodule

`default_nettype wire

// File: design/operand_order.sv
////////////////////////////////////////////////////////////
// Input gating, accumulator select and magnitude ordering
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module operand_order
    import posit_accum_pkg::*;
(
    input  wire logic         clk,
    input  wire logic         rst,
    input  wire posit_value_t in_value,
    input  wire logic         start,
    input  wire accum_value_t acc,
    input  wire logic         acc_clear,
    output order_stage_t      ord
);

    accum_value_t in_wide;
    accum_value_t acc_sel;
    accum_value_t hi;
    accum_value_t lo;
    logic         in_is_hi;

    // Widen the input fraction, zero fill at the bottom
    always_comb
    begin
        in_wide = ACC_ZERO;
        if (start)
        begin
            in_wide.inf  = in_value.inf;
            in_wide.zero = in_value.zero;
            // A zero input carries no magnitude bits
            if (!in_value.zero)
            begin
                in_wide.sgn      = in_value.sgn;
                in_wide.scale    = in_value.scale;
                in_wide.fraction = {in_value.fraction, {(ACC_FRAC_W - FRAC_W){1'b0}}};
            end
        end
    end

    assign acc_sel = acc_clear ? ACC_ZERO : acc;

    // Zero flags first, then scale, then fraction
    always_comb
    begin
        if (acc_sel.zero)
        begin
            in_is_hi = 1'b1;
        end
        else if (in_wide.zero)
        begin
            in_is_hi = 1'b0;
        end
        else if (in_wide.scale != acc_sel.scale)
        begin
            in_is_hi = $signed(in_wide.scale) > $signed(acc_sel.scale);
        end
        else
        begin
            in_is_hi = in_wide.fraction >= acc_sel.fraction;
        end
    end

    assign hi = in_is_hi ? in_wide : acc_sel;
    assign lo = in_is_hi ? acc_sel : in_wide;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            ord <= '{hi: ACC_ZERO, lo: ACC_ZERO, subtract: 1'b0, scale_diff: '0};
        end
        else
        begin
            ord.hi         <= hi;
            ord.lo         <= lo;
            ord.subtract   <= hi.sgn ^ lo.sgn;
            ord.scale_diff <= hi.scale - lo.scale;
        end
    end

endmodule

`default_nettype wire

// File: design/align_shift.sv
////////////////////////////////////////////////////////////
// Alignment of the smaller magnitude to the larger scale
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module align_shift
    import posit_accum_pkg::*;
(
    input  wire logic         clk,
    input  wire logic         rst,
    input  wire order_stage_t ord,
    output align_stage_t      aln
);

    logic [MAG_W-1:0] lo_mant;
    logic [MAG_W-1:0] lo_aligned;
    logic [MAG_W-1:0] shift_rem;
    logic             lost;

    always_comb
    begin
        lo_mant = {~ord.lo.zero, ord.lo.fraction};
        if (ord.scale_diff >= SCALE_W'(MAG_W))
        begin
            // Everything falls off the bottom
            lo_aligned = '0;
            shift_rem  = lo_mant;
        end
        else
        begin
            {lo_aligned, shift_rem} = {lo_mant, {MAG_W{1'b0}}} >> ord.scale_diff;
        end
        lost = |shift_rem;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            aln <= '{hi: ACC_ZERO, lo_mag: '0, lo_inf: 1'b0, lo_zero: 1'b1,
                     subtract: 1'b0, truncated: 1'b0};
        end
        else
        begin
            aln.hi        <= ord.hi;
            aln.lo_mag    <= lo_aligned;
            aln.lo_inf    <= ord.lo.inf;
            aln.lo_zero   <= ord.lo.zero;
            aln.subtract  <= ord.subtract;
            aln.truncated <= lost;
        end
    end

endmodule

`default_nettype wire

// File: design/frac_addsub.sv
////////////////////////////////////////////////////////////
// Magnitude add or subtract of the aligned operands
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module frac_addsub
    import posit_accum_pkg::*;
(
    input  wire logic         clk,
    input  wire logic         rst,
    input  wire align_stage_t aln,
    output sum_stage_t        sum
);

    logic [MAG_W:0] hi_mag;
    logic [MAG_W:0] lo_mag;

    // Extra top bit catches the carry
    assign hi_mag = {1'b0, ~aln.hi.zero, aln.hi.fraction};
    assign lo_mag = {1'b0, aln.lo_mag};

    // hi is never smaller than lo, so a difference stays non negative
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            sum <= '{sgn: 1'b0, scale: '0, inf: 1'b0, zero: 1'b1, raw: '0, truncated: 1'b0};
        end
        else
        begin
            sum.raw       <= aln.subtract ? (hi_mag - lo_mag) : (hi_mag + lo_mag);
            sum.sgn       <= aln.hi.sgn;
            sum.scale     <= aln.hi.scale;
            sum.inf       <= aln.hi.inf | aln.lo_inf;
            sum.zero      <= aln.hi.zero & aln.lo_zero;
            sum.truncated <= aln.truncated;
        end
    end

endmodule

`default_nettype wire

// File: design/normalize.sv
////////////////////////////////////////////////////////////
// Renormalization: leading one search and scale update,
// then left shift into the accumulator format
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module normalize
    import posit_accum_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire sum_stage_t sum,
    output accum_value_t    result,
    output logic            truncated
);

    norm_stage_t      nrm_d;
    norm_stage_t      nrm;
    logic [LOD_W-1:0] lsh;
    logic [MAG_W:0]   shifted;
    accum_value_t     res_d;

    // Stage 1
    always_comb
    begin
        nrm_d.sum     = sum;
        nrm_d.lod_pos = '0;
        for (int i = 0; i <= MAG_W; i++)
        begin
            if (sum.raw[i])
            begin
                nrm_d.lod_pos = LOD_W'(i);
            end
        end
        // Hidden bit sits at ACC_FRAC_W, a carry lands one above it
        nrm_d.scale_adj = sum.scale + SCALE_W'(nrm_d.lod_pos) - SCALE_W'(ACC_FRAC_W);
        nrm_d.sum.zero  = sum.zero | ~|sum.raw;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            nrm <= '{sum: '{sgn: 1'b0, scale: '0, inf: 1'b0, zero: 1'b1, raw: '0,
                            truncated: 1'b0},
                     lod_pos: '0, scale_adj: '0};
        end
        else
        begin
            nrm <= nrm_d;
        end
    end

    // Stage 2, leading one moved to the top bit and then dropped
    assign lsh     = LOD_W'(MAG_W) - nrm.lod_pos;
    assign shifted = nrm.sum.raw << lsh;

    always_comb
    begin
        res_d = ACC_ZERO;
        res_d.inf = nrm.sum.inf;
        // Exact cancellation leaves sign and scale cleared
        if (!nrm.sum.zero)
        begin
            res_d.sgn      = nrm.sum.sgn;
            res_d.scale    = nrm.scale_adj;
            res_d.fraction = shifted[MAG_W-1:1];
            res_d.zero     = 1'b0;
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            result    <= ACC_ZERO;
            truncated <= 1'b0;
        end
        else
        begin
            result    <= res_d;
            truncated <= nrm.sum.truncated;
        end
    end

endmodule

`default_nettype wire

// File: design/posit_accum_top.sv
////////////////////////////////////////////////////////////
// Pipelined posit accumulator, control and datapath ring
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module posit_accum_top
    import posit_accum_pkg::*;
(
    input  wire logic         clk,
    input  wire logic         rst,
    input  wire posit_value_t in_value,
    input  wire logic         start,
    input  wire logic         clear,
    output accum_value_t      result,
    output logic              done,
    output logic              truncated
);

    logic         acc_clear;
    order_stage_t ord;
    align_stage_t aln;
    sum_stage_t   sum;

    // Done follows start through the same number of stages as the data
    accum_ctrl u_ctrl (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .clear     (clear),
        .acc_clear (acc_clear),
        .done      (done)
    );

    // Ring entry, result comes back as the running sum of the lane
    operand_order u_order (
        .clk       (clk),
        .rst       (rst),
        .in_value  (in_value),
        .start     (start),
        .acc       (result),
        .acc_clear (acc_clear),
        .ord       (ord)
    );

    align_shift u_align (
        .clk (clk),
        .rst (rst),
        .ord (ord),
        .aln (aln)
    );

    frac_addsub u_addsub (
        .clk (clk),
        .rst (rst),
        .aln (aln),
        .sum (sum)
    );

    // Two register stages, closes the loop of LOOP_DEPTH cycles
    normalize u_norm (
        .clk       (clk),
        .rst       (rst),
        .sum       (sum),
        .result    (result),
        .truncated (truncated)
    );

endmodule

`default_nettype wire

// File: testbench/tb_clock_gen.sv
////////////////////////////////////////////////////////////
// Testbench clock, 100 ns period, and power-on reset
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen
(
    output logic clk,
    output logic rst
);

    localparam int HALF_PERIOD  = 50;
    localparam int RESET_CYCLES = 2;

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #HALF_PERIOD clk = ~clk;
        end
    end

    // Released on a falling edge, away from the sampling edge
    initial
    begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

`default_nettype wire

// File: testbench/tb_posit_accum.sv
////////////////////////////////////////////////////////////
// Testbench for the posit accumulator with LCG stimulus,
// five-lane reference model, compare tasks and timeout
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module tb_posit_accum
    import posit_accum_pkg::*;
();

    localparam int          NUM_CYCLES     = 2000;
    localparam int          LONE_PHASE     = 20;
    localparam int          INF_AT         = 500;
    localparam int          CLEAR_AT       = 1000;
    localparam int          TIMEOUT_CYCLES = NUM_CYCLES + 100;
    localparam logic [31:0] SEED           = 32'h8885;
    localparam int          PAD_W          = ACC_FRAC_W - FRAC_W;

    localparam posit_value_t IDLE_INPUT = '{
        sgn: 1'b0, scale: '0, fraction: '0, inf: 1'b0, zero: 1'b1
    };

    typedef struct packed {
        logic         done;
        accum_value_t result;
        logic         truncated;
    } expect_t;

    logic         clk;
    logic         rst;
    posit_value_t in_value;
    logic         start;
    logic         clear;
    accum_value_t result;
    logic         done;
    logic         truncated;

    accum_value_t lanes [LOOP_DEPTH];
    expect_t      exp_q [$];
    expect_t      exp_now;
    logic [31:0]  rng_state;
    int           clear_left;
    int           cycle_count;

    tb_clock_gen u_clk (
        .clk (clk),
        .rst (rst)
    );

    posit_accum_top uut (
        .clk       (clk),
        .rst       (rst),
        .in_value  (in_value),
        .start     (start),
        .clear     (clear),
        .result    (result),
        .done      (done),
        .truncated (truncated)
    );

    task automatic abort_run();
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_result(input accum_value_t got, input accum_value_t exp,
                                input string name);
        if (got !== exp)
        begin
            $display("[FAIL] time %0t %s got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string name);
        if (got !== exp)
        begin
            $display("[FAIL] time %0t %s got %b expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    // A started sum must come out with its done pulse
    task automatic check_done_missing(input logic got);
        if (got !== 1'b1)
        begin
            $display("[FAIL] time %0t done got %b expected 1 for a started sum",
                     $time, got);
            abort_run();
        end
    endtask

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Upper halves of two steps since the low LCG bits are weak
    task automatic next_random(output logic [31:0] value);
        logic [31:0] first;
        rng_state = lcg_step(rng_state);
        first     = rng_state;
        rng_state = lcg_step(rng_state);
        value     = {first[31:16], rng_state[31:16]};
    endtask

    function automatic accum_value_t widen_input(input posit_value_t v, input logic st);
        accum_value_t w;
        w = ACC_ZERO;
        if (st)
        begin
            w.inf  = v.inf;
            w.zero = v.zero;
            if (!v.zero)
            begin
                w.sgn      = v.sgn;
                w.scale    = v.scale;
                w.fraction = {v.fraction, {PAD_W{1'b0}}};
            end
        end
        return w;
    endfunction

    // Lane value that an opposite-sign input can cancel exactly
    function automatic logic can_cancel(input accum_value_t a);
        return !a.zero && !a.inf && (a.fraction[PAD_W-1:0] == '0) &&
               (int'(a.scale) >= -40) && (int'(a.scale) <= 40);
    endfunction

    // Reference sum on wide integers where value = mant * 2^(scale - ACC_FRAC_W)
    task automatic reference_add(input accum_value_t a, input accum_value_t b,
                                 output accum_value_t res, output logic trunc);
        accum_value_t hi;
        accum_value_t lo;
        logic [63:0]  hi_m;
        logic [63:0]  lo_m;
        logic [63:0]  al;
        logic [63:0]  raw;
        logic         a_is_hi;
        int           diff;
        int           p;
        if (b.zero)
            a_is_hi = 1'b1;
        else if (a.zero)
            a_is_hi = 1'b0;
        else if (int'(a.scale) != int'(b.scale))
            a_is_hi = int'(a.scale) > int'(b.scale);
        else
            a_is_hi = a.fraction >= b.fraction;
        hi   = a_is_hi ? a : b;
        lo   = a_is_hi ? b : a;
        hi_m = hi.zero ? 64'd0 : ((64'd1 << ACC_FRAC_W) | 64'(hi.fraction));
        lo_m = lo.zero ? 64'd0 : ((64'd1 << ACC_FRAC_W) | 64'(lo.fraction));
        diff = int'(hi.scale) - int'(lo.scale);
        al    = 64'd0;
        trunc = 1'b0;
        if (lo_m != 64'd0)
        begin
            if (diff > ACC_FRAC_W)
                trunc = 1'b1;
            else
            begin
                al    = lo_m >> diff;
                trunc = (al << diff) != lo_m;
            end
        end
        raw = (hi.sgn != lo.sgn) ? hi_m - al : hi_m + al;
        res     = ACC_ZERO;
        res.inf = a.inf | b.inf;
        if (raw != 64'd0)
        begin
            p = 0;
            for (int i = 0; i < 64; i++)
            begin
                if (raw[i])
                    p = i;
            end
            res.sgn   = hi.sgn;
            res.zero  = 1'b0;
            res.scale = SCALE_W'(int'(hi.scale) + p - ACC_FRAC_W);
            // Drop the leading one and keep the next ACC_FRAC_W bits
            raw = raw - (64'd1 << p);
            if (p >= ACC_FRAC_W)
                res.fraction = ACC_FRAC_W'(raw >> (p - ACC_FRAC_W));
            else
                res.fraction = ACC_FRAC_W'(raw << (ACC_FRAC_W - p));
        end
    endtask

    // Outputs after edge k belong to the sample taken at edge k-4
    always @(negedge clk)
    begin
        if (rst === 1'b0)
        begin
            if (exp_q.size() > LOOP_DEPTH)
                exp_now = exp_q.pop_front();
            else
            begin
                exp_now.done      = 1'b0;
                exp_now.result    = ACC_ZERO;
                exp_now.truncated = 1'b0;
            end
            if (exp_now.done)
                check_done_missing(done);
            else
                check_flag(done, 1'b0, "done");
            check_result(result, exp_now.result, "result");
            check_flag(truncated, exp_now.truncated, "truncated");
        end
    end

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("Timeout after %0d cycles, the run did not finish", cycle_count);
            abort_run();
        end
    end

    initial
    begin
        posit_value_t v;
        accum_value_t lane_val;
        accum_value_t res;
        expect_t      e;
        logic         st;
        logic         clr;
        logic         tr;
        logic         acc_clr;
        logic [31:0]  r;
        logic [31:0]  rs;
        logic [31:0]  rf;
        int           lane;

        in_value    <= IDLE_INPUT;
        start       <= 1'b0;
        clear       <= 1'b0;
        rng_state   = SEED;
        clear_left  = 0;
        cycle_count = 0;
        for (int k = 0; k < LOOP_DEPTH; k++)
            lanes[k] = ACC_ZERO;

        wait (rst === 1'b0);
        // A few idle cycles at the end let the last sums come out
        for (int i = 0; i < NUM_CYCLES + LOOP_DEPTH + 1; i++)
        begin
            @(posedge clk);
            lane = i % LOOP_DEPTH;
            st   = 1'b0;
            clr  = 1'b0;
            v    = IDLE_INPUT;
            if (i < NUM_CYCLES)
            begin
                next_random(r);
                next_random(rs);
                next_random(rf);
                // Lone starts first and then a start on most cycles
                if (i < LONE_PHASE)
                    st = (i == 3) || (i == 12);
                else
                begin
                    st  = (r[2:0] != 3'd0) || (i == INF_AT);
                    clr = (i == CLEAR_AT) || (r[15:8] == 8'hA5);
                end
                v.sgn      = r[28];
                v.scale    = SCALE_W'(int'(rs % 32'd81) - 40);
                v.fraction = rf[FRAC_W-1:0];
                v.zero     = (i >= LONE_PHASE) && (i != INF_AT) && (r[27:23] == 5'd0);
                v.inf      = !v.zero && ((i == INF_AT) ||
                             ((i >= LONE_PHASE) && (r[22:16] == 7'd0)));
            end
            if (clr)
                clear_left = LOOP_DEPTH;
            acc_clr  = clear_left > 0;
            lane_val = acc_clr ? ACC_ZERO : lanes[lane];
            // Exact cancellation is forced on the lanes refilled after the mid-run clear
            if (st && can_cancel(lane_val) && ((r[7:5] == 3'd0) ||
                (i >= CLEAR_AT + LOOP_DEPTH && i < CLEAR_AT + 2 * LOOP_DEPTH)))
            begin
                v.sgn      = ~lane_val.sgn;
                v.scale    = lane_val.scale;
                v.fraction = lane_val.fraction[ACC_FRAC_W-1 -: FRAC_W];
                v.inf      = 1'b0;
                v.zero     = 1'b0;
            end
            start    <= st;
            clear    <= clr;
            in_value <= v;
            reference_add(widen_input(v, st), lane_val, res, tr);
            lanes[lane] = res;
            e.done      = st;
            e.result    = res;
            e.truncated = tr;
            exp_q.push_back(e);
            if (clear_left > 0)
                clear_left--;
        end

        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
design/posit_accum_pkg.sv
design/accum_ctrl.sv
design/operand_order.sv
design/align_shift.sv
design/frac_addsub.sv
design/normalize.sv
design/posit_accum_top.sv
testbench/tb_clock_gen.sv
testbench/tb_posit_accum.sv

// File: Makefile
# Verilator build and run for the posit accumulator testbench

SIM      = verilator
TOP      = tb_posit_accum
FILELIST = filelist.f
FLAGS    = --binary --timing -Wno-fatal --top-module $(TOP)
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = All tests passed!

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --Mdir $(BUILD) -f $(FILELIST)

# Pass or fail is decided by the log, not by the exit status of the pipe
run: compile
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG) && echo "Simulation passed" || \
		{ echo "Simulation failed"; exit 1; }

clean:
	rm -rf $(BUILD) $(LOG)
